// File: chessEngine.f
+incdir+src
src/chessPiecePkg.sv
src/chessMovePkg.sv
src/slidingMoveGen.sv
src/stepMoveGen.sv
src/boardController.sv
src/chessEngine.sv
verification/chessEngine_assertions.sv
verification/chessEngine_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the chess engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module chessEngine_tb \
    -f chessEngine.f -Mdir "$OBJ"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$OBJ/VchessEngine_tb" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1

// File: verification/chessEngine_tb.sv
`timescale 1ns/1ps

module chessEngine_tb;
    import chessPiecePkg::*;
    import chessMovePkg::*;

    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 16;
    localparam int STEP_CYCLES  = 3;   // drive edge plus two hold edges
    localparam int MARGIN       = 20;

    typedef struct {
        string    name;
        colourT   player;
        coordT    row;
        coordT    col;
        moveMaskT expMask;
        int       expPulses;   // moved pulses during the step
        coordT    expOldX;
        coordT    expOldY;
        coordT    expNewX;
        coordT    expNewY;
    } stepT;

    logic     CLOCK = 1'b0;
    logic     rstN;
    colourT   player;
    coordT    coordX;
    coordT    coordY;
    coordT    oldPosX;
    coordT    oldPosY;
    coordT    newPosX;
    coordT    newPosY;
    logic     moved;
    moveMaskT availMoves;

    stepT  steps[$];
    int    errCount   = 0;
    int    pulseCount = 0;
    int    seed       = 80;
    coordT seenOldX;   // positions latched at the moved pulse
    coordT seenOldY;
    coordT seenNewX;
    coordT seenNewY;

    always #(PERIOD / 2) CLOCK = ~CLOCK;

    chessEngine dut_i (
        .CLOCK      (CLOCK),
        .rstN       (rstN),
        .player     (player),
        .coordX     (coordX),
        .coordY     (coordY),
        .oldPosX    (oldPosX),
        .oldPosY    (oldPosY),
        .newPosX    (newPosX),
        .newPosY    (newPosY),
        .moved      (moved),
        .availMoves (availMoves)
    );

    // the pulse lasts one cycle, so catch it mid cycle
    always @(negedge CLOCK) begin
        if (rstN && moved) begin
            pulseCount++;
            seenOldX = oldPosX;
            seenOldY = oldPosY;
            seenNewX = newPosX;
            seenNewY = newPosY;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table

    function automatic moveMaskT bitAt(int row, int col);
        return moveMaskT'(1) << (row * 8 + col);  // bit 8*row+col
    endfunction

    task automatic addStep(input string name, input colourT who, input int row, input int col,
                           input moveMaskT mask, input int pulses,
                           input int oldX, input int oldY, input int newX, input int newY);
        stepT s;
        s.name      = name;
        s.player    = who;
        s.row       = coordT'(row);
        s.col       = coordT'(col);
        s.expMask   = mask;
        s.expPulses = pulses;
        s.expOldX   = coordT'(oldX);
        s.expOldY   = coordT'(oldY);
        s.expNewX   = coordT'(newX);
        s.expNewY   = coordT'(newY);
        steps.push_back(s);
    endtask

    task automatic buildSteps();
        moveMaskT e2Mask;
        moveMaskT h5Mask;
        int       randRow;
        int       randCol;
        e2Mask  = bitAt(5, 4) | bitAt(4, 4);
        // queen on h5 after 1.e4 e5 2.Qh5, captures on h7, f7 and e5
        h5Mask  = bitAt(2, 7) | bitAt(1, 7) | bitAt(4, 7) | bitAt(5, 7) |
                  bitAt(3, 6) | bitAt(3, 5) | bitAt(3, 4) | bitAt(2, 6) | bitAt(1, 5) |
                  bitAt(4, 6) | bitAt(5, 5) | bitAt(6, 4) | bitAt(7, 3);
        randRow = 2 + int'($unsigned($random(seed)) % 4);
        randCol = int'($unsigned($random(seed)) % 8);
        if ((bitAt(randRow, randCol) & e2Mask) != '0) begin
            randCol = (randCol + 1) % 8;  // keep clear of the pawn targets
        end
        addStep("pawnE2Select", colWhite, 6, 4, e2Mask, 0, 6, 4, 0, 0);
        addStep("emptySquareNop", colWhite, randRow, randCol, e2Mask, 0, 6, 4, 0, 0);
        addStep("opponentNop", colWhite, 1, 3, e2Mask, 0, 6, 4, 0, 0);
        addStep("knightB8Select", colBlack, 0, 1, bitAt(2, 0) | bitAt(2, 2), 0, 0, 1, 0, 0);
        addStep("rookA1Select", colWhite, 7, 0, '0, 0, 7, 0, 0, 0);
        addStep("pawnE2Reselect", colWhite, 6, 4, e2Mask, 0, 6, 4, 0, 0);
        addStep("moveE2E4", colWhite, 4, 4, '0, 1, 6, 4, 4, 4);
        addStep("pawnE7Select", colBlack, 1, 4, bitAt(2, 4) | bitAt(3, 4), 0, 1, 4, 4, 4);
        addStep("moveE7E5", colBlack, 3, 4, '0, 1, 1, 4, 3, 4);
        addStep("bishopF1Select", colWhite, 7, 5,
                bitAt(6, 4) | bitAt(5, 3) | bitAt(4, 2) | bitAt(3, 1) | bitAt(2, 0),
                0, 7, 5, 3, 4);
        addStep("queenD1Select", colWhite, 7, 3,
                bitAt(6, 4) | bitAt(5, 5) | bitAt(4, 6) | bitAt(3, 7), 0, 7, 3, 3, 4);
        addStep("moveQd1H5", colWhite, 3, 7, '0, 1, 7, 3, 3, 7);
        addStep("queenH5Select", colWhite, 3, 7, h5Mask, 0, 3, 7, 3, 7);
        addStep("queenOffMaskNop", colWhite, 2, 0, h5Mask, 0, 3, 7, 3, 7);
        addStep("kingE1Select", colWhite, 7, 4, '0, 0, 7, 4, 3, 7);
        addStep("kingOffMaskNop", colWhite, 6, 4, '0, 0, 7, 4, 3, 7);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks

    task automatic checkReset();
        assert (!moved && availMoves == '0) else begin
            $display("[FAIL] afterReset moved/availMoves expected 0/0 actual %b/%h",
                     moved, availMoves);
            errCount++;
        end
        assert ({oldPosX, oldPosY, newPosX, newPosY} == '0) else begin
            $display("[FAIL] afterReset positions expected 0 actual %h",
                     {oldPosX, oldPosY, newPosX, newPosY});
            errCount++;
        end
    endtask

    task automatic checkStep(input stepT s, input int pulses);
        coordT gotOldX;
        coordT gotOldY;
        coordT gotNewX;
        coordT gotNewY;
        gotOldX = (s.expPulses > 0) ? seenOldX : oldPosX;
        gotOldY = (s.expPulses > 0) ? seenOldY : oldPosY;
        gotNewX = (s.expPulses > 0) ? seenNewX : newPosX;
        gotNewY = (s.expPulses > 0) ? seenNewY : newPosY;
        assert (availMoves == s.expMask) else begin
            $display("[FAIL] %s availMoves expected %h actual %h",
                     s.name, s.expMask, availMoves);
            errCount++;
        end
        assert (pulses == s.expPulses) else begin
            $display("[FAIL] %s moved pulses expected %0d actual %0d",
                     s.name, s.expPulses, pulses);
            errCount++;
        end
        assert (gotOldX == s.expOldX && gotOldY == s.expOldY) else begin
            $display("[FAIL] %s old position expected (%0d,%0d) actual (%0d,%0d)",
                     s.name, s.expOldX, s.expOldY, gotOldX, gotOldY);
            errCount++;
        end
        assert (gotNewX == s.expNewX && gotNewY == s.expNewY) else begin
            $display("[FAIL] %s new position expected (%0d,%0d) actual (%0d,%0d)",
                     s.name, s.expNewX, s.expNewY, gotNewX, gotNewY);
            errCount++;
        end
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge CLOCK);
        $display("timeout: the run did not finish within %0d cycles", cycles);
        $display("Something failed");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int pulsesBefore;
        rstN   = 1'b0;
        player = colWhite;
        coordX = '0;
        coordY = '0;
        buildSteps();
        fork
            watchdog(steps.size() * STEP_CYCLES + RESET_CYCLES + MARGIN);
        join_none
        repeat (RESET_CYCLES) @(posedge CLOCK);
        rstN <= 1'b1;
        @(negedge CLOCK);
        checkReset();
        foreach (steps[i]) begin
            pulsesBefore = pulseCount;
            @(posedge CLOCK);
            player <= steps[i].player;
            coordX <= steps[i].row;
            coordY <= steps[i].col;
            repeat (2) @(posedge CLOCK);
            @(negedge CLOCK);
            checkStep(steps[i], pulseCount - pulsesBefore);
        end
        $display("checks failed: %0d, assertion failures: %0d",
                 errCount, dut_i.checks_i.failCount);
        if (errCount == 0 && dut_i.checks_i.failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verification/chessEngine_assertions.sv
`timescale 1ns/1ps

module chessEngine_assertions (
    input logic                   CLOCK,
    input logic                   rstN,
    input logic                   moved,
    input chessMovePkg::moveMaskT availMoves,
    input chessPiecePkg::coordT   oldPosX,
    input chessPiecePkg::coordT   oldPosY,
    input chessPiecePkg::coordT   newPosX,
    input chessPiecePkg::coordT   newPosY
);
    int failCount = 0;  // read by the testbench at the end

    // a commit is a single cycle pulse
    singlePulse: assert property (@(posedge CLOCK) disable iff (!rstN) moved |=> !moved)
        else begin
            failCount++;
            $error("moved stayed high for two cycles");
        end

    // selection is dropped with the commit
    clearAfterMove: assert property (@(posedge CLOCK) disable iff (!rstN)
        moved |=> availMoves == '0)
        else begin
            failCount++;
            $error("availMoves not cleared after a move");
        end

    quietInReset: assert property (@(posedge CLOCK) !rstN |=>
        (!moved && availMoves == '0 && oldPosX == '0 && oldPosY == '0 &&
         newPosX == '0 && newPosY == '0))
        else begin
            failCount++;
            $error("outputs not zero during reset");
        end

endmodule

bind chessEngine chessEngine_assertions checks_i (
    .CLOCK      (CLOCK),
    .rstN       (rstN),
    .moved      (moved),
    .availMoves (availMoves),
    .oldPosX    (oldPosX),
    .oldPosY    (oldPosY),
    .newPosX    (newPosX),
    .newPosY    (newPosY)
);

// File: src/chessEngine.sv
`timescale 1ns/1ps

module chessEngine (
    input  logic                   CLOCK,
    input  logic                   rstN,
    input  chessPiecePkg::colourT  player,
    input  chessPiecePkg::coordT   coordX,
    input  chessPiecePkg::coordT   coordY,
    output chessPiecePkg::coordT   oldPosX,
    output chessPiecePkg::coordT   oldPosY,
    output chessPiecePkg::coordT   newPosX,
    output chessPiecePkg::coordT   newPosY,
    output logic                   moved,
    output chessMovePkg::moveMaskT availMoves
);
    import chessPiecePkg::*;
    import chessMovePkg::*;

    boardT    board;
    coordT    selRow;
    coordT    selCol;
    squareT   selPiece;
    moveMaskT rayMask;   // bishop, rook, queen
    moveMaskT stepMask;  // pawn, knight

    boardController ctrl_i (
        .CLOCK      (CLOCK),
        .rstN       (rstN),
        .player     (player),
        .coordX     (coordX),
        .coordY     (coordY),
        .rayMask    (rayMask),
        .stepMask   (stepMask),
        .board      (board),
        .selRow     (selRow),
        .selCol     (selCol),
        .selPiece   (selPiece),
        .oldPosX    (oldPosX),
        .oldPosY    (oldPosY),
        .newPosX    (newPosX),
        .newPosY    (newPosY),
        .moved      (moved),
        .availMoves (availMoves)
    );

    slidingMoveGen slide_i (
        .board    (board),
        .selRow   (selRow),
        .selCol   (selCol),
        .selPiece (selPiece),
        .rayMask  (rayMask)
    );

    stepMoveGen step_i (
        .board    (board),
        .selRow   (selRow),
        .selCol   (selCol),
        .selPiece (selPiece),
        .stepMask (stepMask)
    );

endmodule

// File: src/boardController.sv
`timescale 1ns/1ps

`include "chess_settings.svh"

module boardController (
    input  logic                   CLOCK,
    input  logic                   rstN,
    input  chessPiecePkg::colourT  player,
    input  chessPiecePkg::coordT   coordX,
    input  chessPiecePkg::coordT   coordY,
    input  chessMovePkg::moveMaskT rayMask,
    input  chessMovePkg::moveMaskT stepMask,
    output chessPiecePkg::boardT   board,
    output chessPiecePkg::coordT   selRow,
    output chessPiecePkg::coordT   selCol,
    output chessPiecePkg::squareT  selPiece,
    output chessPiecePkg::coordT   oldPosX,
    output chessPiecePkg::coordT   oldPosY,
    output chessPiecePkg::coordT   newPosX,
    output chessPiecePkg::coordT   newPosY,
    output logic                   moved,
    output chessMovePkg::moveMaskT availMoves
);
    import chessPiecePkg::*;
    import chessMovePkg::*;

    // back rank order, column 0 to 7, same for both sides
    localparam pieceKindT backRank [`BOARD_DIM] = '{
        pieceRook, pieceKnight, pieceBishop, pieceQueen,
        pieceKing, pieceBishop, pieceKnight, pieceRook
    };

    ////////////////////////////////////////////////////////////////////////////
    // opening position

    function automatic boardT openingBoard();
        boardT b;
        b = '0;  // middle rows empty
        for (int col = 0; col < `BOARD_DIM; col++) begin
            b[`BLACK_BACK_ROW][col] = '{colour: colBlack, kind: backRank[col]};
            b[`BLACK_PAWN_ROW][col] = '{colour: colBlack, kind: piecePawn};
            b[`WHITE_PAWN_ROW][col] = '{colour: colWhite, kind: piecePawn};
            b[`WHITE_BACK_ROW][col] = '{colour: colWhite, kind: backRank[col]};
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // decode of the sampled coordinate

    squareT   sampled;     // piece under the cursor
    logic     selectable;  // own piece, becomes the new selection
    logic     commit;      // marked target, move goes through
    moveMaskT mergedMask;

    assign sampled    = board[coordX][coordY];
    assign selectable = sampled.kind != pieceEmpty && sampled.colour == player;
    assign commit     = !selectable && availMoves[squareIndex(coordX, coordY)];
    assign mergedMask = rayMask | stepMask;

    // generators read the origin straight from the old position regs
    assign selRow = oldPosX;
    assign selCol = oldPosY;

    ////////////////////////////////////////////////////////////////////////////
    // board, selection and move registers

    always_ff @(posedge CLOCK) begin
        if (!rstN) begin
            board      <= openingBoard();
            selPiece   <= '0;
            oldPosX    <= '0;
            oldPosY    <= '0;
            newPosX    <= '0;
            newPosY    <= '0;
            moved      <= 1'b0;
            availMoves <= '0;
        end else begin
            moved      <= 1'b0;
            availMoves <= mergedMask;  // one cycle behind the selection
            if (selectable) begin
                selPiece <= sampled;
                oldPosX  <= coordX;
                oldPosY  <= coordY;
            end else if (commit) begin
                board[coordX][coordY]   <= selPiece;
                board[oldPosX][oldPosY] <= '0;  // origin emptied
                newPosX    <= coordX;
                newPosY    <= coordY;
                moved      <= 1'b1;
                availMoves <= '0;
                selPiece   <= '0;  // generators go quiet
            end
        end
    end

endmodule

// File: src/stepMoveGen.sv
`timescale 1ns/1ps

`include "chess_settings.svh"

module stepMoveGen (
    input  chessPiecePkg::boardT   board,
    input  chessPiecePkg::coordT   selRow,
    input  chessPiecePkg::coordT   selCol,
    input  chessPiecePkg::squareT  selPiece,
    output chessMovePkg::moveMaskT stepMask
);
    import chessPiecePkg::*;
    import chessMovePkg::*;

    // knight jump offsets, row and column
    localparam int knightRowOfs [`KNIGHT_JUMPS] = '{-2, -2, -1, -1, 1, 1, 2, 2};
    localparam int knightColOfs [`KNIGHT_JUMPS] = '{-1, 1, -2, 2, -2, 2, -1, 1};

    // empty or held by the other side
    function automatic logic isOpen(squareT sq, colourT mover);
        return sq.kind == pieceEmpty || sq.colour != mover;
    endfunction

    function automatic logic isEnemy(squareT sq, colourT mover);
        return sq.kind != pieceEmpty && sq.colour != mover;
    endfunction

    logic   isWhite;
    int     fwd;       // pawn direction
    int     startRow;  // double step allowed here

    assign isWhite  = selPiece.colour == colWhite;
    assign fwd      = isWhite ? -1 : 1;
    assign startRow = isWhite ? `WHITE_PAWN_ROW : `BLACK_PAWN_ROW;

    ////////////////////////////////////////////////////////////////////////////
    // pawn and knight targets

    always_comb begin
        int r;
        int c;
        stepMask = '0;
        r = 0;
        c = 0;
        if (selPiece.kind == piecePawn) begin
            r = int'(selRow) + fwd;
            if (onBoard(r, int'(selCol)) && board[coordT'(r)][selCol].kind == pieceEmpty) begin
                stepMask[squareIndex(coordT'(r), selCol)] = 1'b1;
                // second step only through an empty first square
                if (int'(selRow) == startRow &&
                    board[coordT'(r + fwd)][selCol].kind == pieceEmpty) begin
                    stepMask[squareIndex(coordT'(r + fwd), selCol)] = 1'b1;
                end
            end
            for (int side = -1; side <= 1; side += 2) begin
                c = int'(selCol) + side;
                if (onBoard(r, c) &&
                    isEnemy(board[coordT'(r)][coordT'(c)], selPiece.colour)) begin
                    stepMask[squareIndex(coordT'(r), coordT'(c))] = 1'b1;  // diagonal capture
                end
            end
        end else if (selPiece.kind == pieceKnight) begin
            for (int k = 0; k < `KNIGHT_JUMPS; k++) begin
                r = int'(selRow) + knightRowOfs[k];
                c = int'(selCol) + knightColOfs[k];
                if (onBoard(r, c) &&
                    isOpen(board[coordT'(r)][coordT'(c)], selPiece.colour)) begin
                    stepMask[squareIndex(coordT'(r), coordT'(c))] = 1'b1;
                end
            end
        end
    end

endmodule

// File: src/slidingMoveGen.sv
`timescale 1ns/1ps

`include "chess_settings.svh"

module slidingMoveGen (
    input  chessPiecePkg::boardT   board,
    input  chessPiecePkg::coordT   selRow,
    input  chessPiecePkg::coordT   selCol,
    input  chessPiecePkg::squareT  selPiece,
    output chessMovePkg::moveMaskT rayMask
);
    import chessPiecePkg::*;
    import chessMovePkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // direction helpers

    function automatic int rowDelta(rayDirT dir);
        case (dir)
            dirN, dirNE, dirNW: return -1;  // toward Black
            dirS, dirSE, dirSW: return 1;
            default:            return 0;
        endcase
    endfunction

    function automatic int colDelta(rayDirT dir);
        case (dir)
            dirE, dirNE, dirSE: return 1;
            dirW, dirNW, dirSW: return -1;
            default:            return 0;
        endcase
    endfunction

    function automatic logic isDiagonal(rayDirT dir);
        return rowDelta(dir) != 0 && colDelta(dir) != 0;
    endfunction

    logic isBishop;
    logic isRook;
    logic isQueen;

    assign isBishop = selPiece.kind == pieceBishop;
    assign isRook   = selPiece.kind == pieceRook;
    assign isQueen  = selPiece.kind == pieceQueen;

    ////////////////////////////////////////////////////////////////////////////
    // ray walk, every direction unrolled

    always_comb begin
        rayDirT dir;
        logic   stopped;
        int     r;
        int     c;
        squareT target;
        rayMask = '0;
        target  = '0;
        for (int d = 0; d < `RAY_DIRS; d++) begin
            dir = rayDirT'(d);
            // directions this piece may not use start out stopped
            stopped = !(isQueen || (isBishop && isDiagonal(dir)) ||
                        (isRook && !isDiagonal(dir)));
            r = int'(selRow);
            c = int'(selCol);
            for (int s = 1; s <= `RAY_STEPS; s++) begin
                r = r + rowDelta(dir);
                c = c + colDelta(dir);
                if (!stopped && onBoard(r, c)) begin
                    target = board[coordT'(r)][coordT'(c)];
                    if (target.kind == pieceEmpty) begin
                        rayMask[squareIndex(coordT'(r), coordT'(c))] = 1'b1;
                    end else begin
                        stopped = 1'b1;  // first piece ends the ray
                        if (target.colour != selPiece.colour) begin
                            rayMask[squareIndex(coordT'(r), coordT'(c))] = 1'b1;  // capture
                        end
                    end
                end
            end
        end
    end

endmodule

// File: src/chessMovePkg.sv
`include "chess_settings.svh"

package chessMovePkg;

    typedef logic [`MASK_W-1:0] moveMaskT;  // bit 8*row+col

    localparam int IDX_W = $clog2(`MASK_W);
    typedef logic [IDX_W-1:0] squareIdxT;

    // north points toward row 0
    typedef enum logic [2:0] {
        dirN, dirNE, dirE, dirSE,
        dirS, dirSW, dirW, dirNW
    } rayDirT;

    // mask bit for a board square
    function automatic squareIdxT squareIndex(chessPiecePkg::coordT row,
                                              chessPiecePkg::coordT col);
        return squareIdxT'(int'(row) * `BOARD_DIM + int'(col));
    endfunction

    // true when a signed row and column lie on the board
    function automatic logic onBoard(int row, int col);
        return row >= 0 && row < `BOARD_DIM && col >= 0 && col < `BOARD_DIM;
    endfunction

endpackage

// File: src/chessPiecePkg.sv
`include "chess_settings.svh"

package chessPiecePkg;

    // piece kinds, same codes as the square encoding on the board
    typedef enum logic [2:0] {
        pieceEmpty  = 3'd0,
        piecePawn   = 3'd1,
        pieceBishop = 3'd2,
        pieceKnight = 3'd3,
        pieceRook   = 3'd4,
        pieceQueen  = 3'd5,
        pieceKing   = 3'd6
    } pieceKindT;

    typedef enum logic {
        colWhite = 1'b0,
        colBlack = 1'b1
    } colourT;

    // colour sits in bit 3, kind in bits 2:0
    typedef struct packed {
        colourT    colour;
        pieceKindT kind;
    } squareT;

    typedef logic [`COORD_W-1:0] coordT;  // row or column

    // board[row][col], 256 bits
    typedef squareT [`BOARD_DIM-1:0][`BOARD_DIM-1:0] boardT;

endpackage

// File: src/chess_settings.svh
`ifndef CHESS_SETTINGS_SVH
`define CHESS_SETTINGS_SVH

// board geometry
`define BOARD_DIM 8   // rows and columns
`define COORD_W   3   // bits per row or column index
`define MASK_W    64  // one bit per square

// rank numbers, row 0 is Black's back rank
`define BLACK_BACK_ROW 0
`define BLACK_PAWN_ROW 1
`define WHITE_PAWN_ROW 6
`define WHITE_BACK_ROW 7

// ray walk limits
`define RAY_DIRS  8   // compass directions
`define RAY_STEPS 7   // longest ray from any square

// knight jumps from one square
`define KNIGHT_JUMPS 8

`endif
